// File: Bender.yml
package:
  name: aes_block

sources:
  - common/aes_pkg.sv
  - aes_core/aes_round_core.sv
  - design/aes_ahb_slave_regs.sv
  - design/aes_ctr_ctrl.sv
  - design/aes_ahb_master_writer.sv
  - design/aes_block.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tb_aes_block.sv

// File: aes_block.f
+incdir+verification
common/aes_pkg.sv
aes_core/aes_round_core.sv
design/aes_ahb_slave_regs.sv
design/aes_ctr_ctrl.sv
design/aes_ahb_master_writer.sv
design/aes_block.sv
verification/tb_aes_block.sv

// File: aes_core/aes_round_core.sv
// Iterative AES-128 encryption only with one round per clock; ROUNDS values other than 10 are untested
`timescale 1ns/1ps

module aes_round_core #(
  parameter int ROUNDS = 10
) (
  input  logic            tb_HCLK,
  input  logic            reset,
  input  logic            core_start,
  input  aes_pkg::block_t core_key,
  input  aes_pkg::block_t core_block,
  output logic            core_done,
  output aes_pkg::block_t core_result
);
  import aes_pkg::*;

  localparam int RW = $clog2(ROUNDS + 1);

  block_t        state_q;
  block_t        rkey_q;
  block_t        rk_next;
  logic [7:0]    rcon_q;
  logic [RW-1:0] round_q;
  logic          busy_q;
  logic          last_round;

  // Next round key from the current one
  function automatic block_t next_key(input block_t k, input logic [7:0] rc);
    word_t w [4];
    word_t tmp;
    for (int i = 0; i < 4; i++)
      w[i] = k[127 - 32 * i -: 32];
    tmp = {sbox(w[3][23:16]), sbox(w[3][15:8]), sbox(w[3][7:0]), sbox(w[3][31:24])}
          ^ {rc, 24'h000000};
    w[0] = w[0] ^ tmp;
    w[1] = w[1] ^ w[0];
    w[2] = w[2] ^ w[1];
    w[3] = w[3] ^ w[2];
    return {w[0], w[1], w[2], w[3]};
  endfunction

  // Byte i is row i%4 of column i/4
  function automatic block_t enc_round(input block_t s, input block_t rk, input logic last);
    logic [7:0] sb [16];
    logic [7:0] sr [16];
    logic [7:0] mc [16];
    block_t     res;
    for (int i = 0; i < 16; i++)
      sb[i] = sbox(s[127 - 8 * i -: 8]);
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < 4; r++)
        sr[4 * c + r] = sb[4 * ((c + r) % 4) + r];
    end
    for (int c = 0; c < 4; c++)
    begin
      mc[4 * c]     = xtime(sr[4 * c]) ^ xtime(sr[4 * c + 1]) ^ sr[4 * c + 1]
                      ^ sr[4 * c + 2] ^ sr[4 * c + 3];
      mc[4 * c + 1] = sr[4 * c] ^ xtime(sr[4 * c + 1]) ^ xtime(sr[4 * c + 2])
                      ^ sr[4 * c + 2] ^ sr[4 * c + 3];
      mc[4 * c + 2] = sr[4 * c] ^ sr[4 * c + 1] ^ xtime(sr[4 * c + 2])
                      ^ xtime(sr[4 * c + 3]) ^ sr[4 * c + 3];
      mc[4 * c + 3] = xtime(sr[4 * c]) ^ sr[4 * c] ^ sr[4 * c + 1] ^ sr[4 * c + 2]
                      ^ xtime(sr[4 * c + 3]);
    end
    for (int i = 0; i < 16; i++)
      res[127 - 8 * i -: 8] = (last ? sr[i] : mc[i]) ^ rk[127 - 8 * i -: 8];
    return res;
  endfunction

  assign rk_next     = next_key(rkey_q, rcon_q);
  assign last_round  = (round_q == RW'(ROUNDS));
  assign core_result = state_q;

  always_ff @(posedge tb_HCLK)
  begin
    if (reset)
    begin
      busy_q    <= 1'b0;
      core_done <= 1'b0;
      round_q   <= '0;
      rcon_q    <= 8'h00;
    end
    else
    begin
      core_done <= 1'b0;
      if (core_start)
      begin
        busy_q  <= 1'b1;
        round_q <= RW'(1);
        rcon_q  <= 8'h01;
      end
      else if (busy_q)
      begin
        round_q <= round_q + 1'b1;
        rcon_q  <= xtime(rcon_q);
        if (last_round)
        begin
          busy_q    <= 1'b0;
          core_done <= 1'b1;
        end
      end
    end
  end

  // Initial AddRoundKey at load, then one full round per cycle
  always_ff @(posedge tb_HCLK)
  begin
    if (core_start)
    begin
      state_q <= core_block ^ core_key;
      rkey_q  <= core_key;
    end
    else if (busy_q)
    begin
      state_q <= enc_round(state_q, rk_next, last_round);
      rkey_q  <= rk_next;
    end
  end

  a_done_pulse: assert property (@(posedge tb_HCLK) disable iff (reset)
    core_done |=> !core_done);

endmodule

// File: common/aes_pkg.sv
// Shared AES-128 CTR types and constants; the S-box is computed in logic and suits 32-bit AHB-Lite only
package aes_pkg;

  typedef logic [31:0] word_t;

  // Word 0 sits in bits 127:96
  typedef logic [127:0] block_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CIPHER,
    ST_WRITE,
    ST_DONE
  } aes_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ADDR,
    WR_DATA,
    WR_ERR
  } wr_state_e;

  typedef struct packed {
    block_t key;
    block_t counter;
    block_t plaintext;
    word_t  dest;
  } job_t;

  typedef struct packed {
    logic  busy;
    logic  done_pulse;
    logic  bus_error;
    word_t next_counter;
  } status_t;

  // Slave register map
  localparam word_t REG_CTRL   = 32'h00;
  localparam word_t REG_STATUS = 32'h04;
  localparam word_t REG_KEY0   = 32'h08;
  localparam word_t REG_KEY1   = 32'h0C;
  localparam word_t REG_KEY2   = 32'h10;
  localparam word_t REG_KEY3   = 32'h14;
  localparam word_t REG_CTR0   = 32'h18;
  localparam word_t REG_CTR1   = 32'h1C;
  localparam word_t REG_CTR2   = 32'h20;
  localparam word_t REG_CTR3   = 32'h24;
  localparam word_t REG_DEST   = 32'h28;
  localparam word_t REG_PT0    = 32'h2C;
  localparam word_t REG_PT1    = 32'h30;
  localparam word_t REG_PT2    = 32'h34;
  localparam word_t REG_PT3    = 32'h38;

  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;
  localparam logic [2:0] HBURST_INCR4  = 3'b011;
  localparam logic [2:0] HSIZE_WORD    = 3'b010;

  // Multiply by x in GF(2^8), reduction polynomial 0x11b
  function automatic logic [7:0] xtime(input logic [7:0] a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] sh;
    acc = 8'h00;
    sh  = a;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
        acc = acc ^ sh;
      sh = xtime(sh);
    end
    return acc;
  endfunction

  // Inverse as b^254, then the affine map
  function automatic logic [7:0] sbox(input logic [7:0] b);
    logic [7:0] sq;
    logic [7:0] inv;
    sq  = b;
    inv = 8'h01;
    for (int i = 1; i < 8; i++)
    begin
      sq  = gf_mul(sq, sq);
      inv = gf_mul(inv, sq);
    end
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
               ^ {inv[3:0], inv[7:4]} ^ 8'h63;
  endfunction

endpackage

// File: design/aes_ahb_master_writer.sv
// Write-only AHB-Lite master issuing one INCR4 word burst per request with no 1 KB boundary check
`timescale 1ns/1ps

module aes_ahb_master_writer (
  input  logic            tb_HCLK,
  input  logic            reset,
  input  logic            wr_valid,
  input  aes_pkg::block_t wr_data,
  input  aes_pkg::word_t  wr_addr,
  input  logic            master_hready,
  input  logic            master_hresp,
  output logic            wr_done,
  output logic            wr_error,
  output aes_pkg::word_t  master_haddr,
  output logic            master_hwrite,
  output logic [2:0]      master_hsize,
  output logic [2:0]      master_hburst,
  output logic [1:0]      master_htrans,
  output aes_pkg::word_t  master_hwdata
);
  import aes_pkg::*;

  wr_state_e  state_q;
  logic [1:0] beat_q;

  assign master_hwrite = 1'b1;
  assign master_hsize  = HSIZE_WORD;
  assign master_hburst = HBURST_INCR4;

  // Payload follows the address phase, word 0 first
  always_ff @(posedge tb_HCLK)
  begin
    if (state_q == WR_IDLE && wr_valid && !wr_done)
      master_haddr <= wr_addr;
    else if (state_q == WR_ADDR && master_hready && !master_hresp)
    begin
      master_hwdata <= wr_data[127 - 32 * beat_q -: 32];
      if (beat_q != 2'd3)
        master_haddr <= master_haddr + 32'd4;
    end
  end

  always_ff @(posedge tb_HCLK)
  begin
    if (reset)
    begin
      state_q       <= WR_IDLE;
      master_htrans <= HTRANS_IDLE;
      beat_q        <= 2'd0;
      wr_done       <= 1'b0;
      wr_error      <= 1'b0;
    end
    else
    begin
      wr_done  <= 1'b0;
      wr_error <= 1'b0;
      case (state_q)
        WR_IDLE:
        begin
          // wr_valid is still up in the cycle after wr_done
          if (wr_valid && !wr_done)
          begin
            master_htrans <= HTRANS_NONSEQ;
            beat_q        <= 2'd0;
            state_q       <= WR_ADDR;
          end
        end
        WR_ADDR:
        begin
          if (master_hresp)
          begin
            master_htrans <= HTRANS_IDLE;
            state_q       <= WR_ERR;
          end
          else if (master_hready)
          begin
            if (beat_q == 2'd3)
            begin
              master_htrans <= HTRANS_IDLE;
              state_q       <= WR_DATA;
            end
            else
            begin
              master_htrans <= HTRANS_SEQ;
              beat_q        <= beat_q + 2'd1;
            end
          end
        end
        WR_DATA:
        begin
          if (master_hresp)
            state_q <= WR_ERR;
          else if (master_hready)
          begin
            wr_done <= 1'b1;
            state_q <= WR_IDLE;
          end
        end
        default:
        begin
          // Wait out the second ERROR cycle
          if (master_hready)
          begin
            wr_done  <= 1'b1;
            wr_error <= 1'b1;
            state_q  <= WR_IDLE;
          end
        end
      endcase
    end
  end

  a_hold_on_stall: assert property (@(posedge tb_HCLK) disable iff (reset)
    (master_htrans != HTRANS_IDLE && !master_hready && !master_hresp)
    |=> $stable(master_haddr) && $stable(master_htrans));

endmodule

// File: design/aes_ahb_slave_regs.sv
// Zero-wait AHB-Lite slave for word-aligned word accesses only, anything else gets a two-cycle ERROR
`timescale 1ns/1ps

module aes_ahb_slave_regs (
  input  logic             tb_HCLK,
  input  logic             reset,
  input  logic             slave_hsel,
  input  aes_pkg::word_t   slave_haddr,
  input  logic             slave_hwrite,
  input  logic [2:0]       slave_hsize,
  input  logic [1:0]       slave_htrans,
  input  logic             slave_hready,
  input  aes_pkg::word_t   slave_hwdata,
  input  aes_pkg::status_t status,
  output aes_pkg::word_t   slave_hrdata,
  output logic             slave_hreadyout,
  output logic             slave_hresp,
  output aes_pkg::job_t    job,
  output logic             start
);
  import aes_pkg::*;

  // Address phase carried into the data phase
  logic   ap_valid;
  logic   ap_write;
  logic   ap_size_ok;
  word_t  ap_addr;

  block_t key_q;
  block_t ctr_q;
  block_t pt_q;
  word_t  dest_q;
  logic   done_q;
  logic   bus_err_q;
  logic   err_second;
  logic   busy;

  word_t  key_off;
  word_t  ctr_off;
  word_t  pt_off;
  logic   hit_ctrl;
  logic   hit_status;
  logic   hit_key;
  logic   hit_ctr;
  logic   hit_dest;
  logic   hit_pt;
  logic   hit_payload;
  logic   bad;
  logic   wr_ok;

  // A pending start counts as busy
  assign busy = status.busy | start;

  assign key_off = ap_addr - REG_KEY0;
  assign ctr_off = ap_addr - REG_CTR0;
  assign pt_off  = ap_addr - REG_PT0;

  assign hit_ctrl    = (ap_addr == REG_CTRL);
  assign hit_status  = (ap_addr == REG_STATUS);
  assign hit_dest    = (ap_addr == REG_DEST);
  assign hit_key     = (ap_addr >= REG_KEY0) && (ap_addr <= REG_KEY3) && (ap_addr[1:0] == 2'b00);
  assign hit_ctr     = (ap_addr >= REG_CTR0) && (ap_addr <= REG_CTR3) && (ap_addr[1:0] == 2'b00);
  assign hit_pt      = (ap_addr >= REG_PT0) && (ap_addr <= REG_PT3) && (ap_addr[1:0] == 2'b00);
  assign hit_payload = hit_key || hit_ctr || hit_dest || hit_pt;

  // Unmapped, wrong size, or job data written while a job runs
  assign bad = ap_valid && (!ap_size_ok || !(hit_ctrl || hit_status || hit_payload)
                            || (ap_write && busy && hit_payload));
  assign wr_ok = ap_valid && ap_write && !bad;

  // first error cycle stalls, second one releases
  assign slave_hreadyout = !bad;
  assign slave_hresp     = bad || err_second;

  assign job = '{key: key_q, counter: ctr_q, plaintext: pt_q, dest: dest_q};

  always_ff @(posedge tb_HCLK)
  begin
    if (!bad && slave_hready)
    begin
      ap_addr    <= slave_haddr;
      ap_write   <= slave_hwrite;
      ap_size_ok <= (slave_hsize == HSIZE_WORD);
    end
  end

  always_ff @(posedge tb_HCLK)
  begin
    if (reset)
    begin
      ap_valid   <= 1'b0;
      err_second <= 1'b0;
      start      <= 1'b0;
      done_q     <= 1'b0;
      bus_err_q  <= 1'b0;
      key_q      <= '0;
      ctr_q      <= '0;
      pt_q       <= '0;
      dest_q     <= '0;
    end
    else
    begin
      err_second <= bad;
      if (bad)
        ap_valid <= 1'b0;
      else if (slave_hready)
        ap_valid <= slave_hsel && slave_htrans[1];
      start <= wr_ok && hit_ctrl && slave_hwdata[0] && !busy;
      if (wr_ok && hit_key)
        key_q[127 - 32 * key_off[3:2] -: 32] <= slave_hwdata;
      if (wr_ok && hit_ctr)
        ctr_q[127 - 32 * ctr_off[3:2] -: 32] <= slave_hwdata;
      if (wr_ok && hit_pt)
        pt_q[127 - 32 * pt_off[3:2] -: 32] <= slave_hwdata;
      if (wr_ok && hit_dest)
        dest_q <= slave_hwdata;
      if (wr_ok && hit_ctrl && slave_hwdata[1])
      begin
        done_q    <= 1'b0;
        bus_err_q <= 1'b0;
      end
      // Completion wins over a clear in the same cycle
      if (status.done_pulse)
      begin
        ctr_q[31:0] <= status.next_counter;
        done_q      <= 1'b1;
        bus_err_q   <= bus_err_q | status.bus_error;
      end
    end
  end

  always_comb
  begin
    slave_hrdata = '0;
    if (hit_status)
      slave_hrdata = {29'd0, bus_err_q, done_q, busy};
    else if (hit_key)
      slave_hrdata = key_q[127 - 32 * key_off[3:2] -: 32];
    else if (hit_ctr)
      slave_hrdata = ctr_q[127 - 32 * ctr_off[3:2] -: 32];
    else if (hit_pt)
      slave_hrdata = pt_q[127 - 32 * pt_off[3:2] -: 32];
    else if (hit_dest)
      slave_hrdata = dest_q;
  end

  // Every ERROR starts stalled and ends with hreadyout back high
  a_err_two_cycle: assert property (@(posedge tb_HCLK) disable iff (reset)
    $rose(slave_hresp) |-> !slave_hreadyout ##1 (slave_hresp && slave_hreadyout));

endmodule

// File: design/aes_block.sv
// AES-128 CTR accelerator top with one block per start, word-only AHB-Lite ports and no interrupt
`timescale 1ns/1ps

module aes_block #(
  parameter int ROUNDS = 10
) (
  input  logic           tb_HCLK,
  input  logic           reset,
  input  logic           slave_hsel,
  input  aes_pkg::word_t slave_haddr,
  input  logic           slave_hwrite,
  input  logic [2:0]     slave_hsize,
  input  logic [1:0]     slave_htrans,
  input  logic           slave_hready,
  input  aes_pkg::word_t slave_hwdata,
  output aes_pkg::word_t slave_hrdata,
  output logic           slave_hreadyout,
  output logic           slave_hresp,
  output aes_pkg::word_t master_haddr,
  output logic           master_hwrite,
  output logic [2:0]     master_hsize,
  output logic [2:0]     master_hburst,
  output logic [1:0]     master_htrans,
  output aes_pkg::word_t master_hwdata,
  input  logic           master_hready,
  input  logic           master_hresp
);
  import aes_pkg::*;

  // Registers and controller
  job_t    job;
  logic    start;
  status_t status;

  // Controller and core
  logic    core_start;
  block_t  core_key;
  block_t  core_block;
  logic    core_done;
  block_t  core_result;

  // controller and writer
  logic    wr_valid;
  block_t  wr_data;
  word_t   wr_addr;
  logic    wr_done;
  logic    wr_error;

  aes_ahb_slave_regs u_regs (.*);

  aes_ctr_ctrl #(.ROUNDS(ROUNDS)) u_ctrl (.*);

  aes_round_core #(.ROUNDS(ROUNDS)) u_core (.*);

  aes_ahb_master_writer u_writer (.*);

endmodule

// File: design/aes_ctr_ctrl.sv
// One CTR block per start with no queueing, and the counter advances in its low 32 bits only
`timescale 1ns/1ps

module aes_ctr_ctrl #(
  parameter int ROUNDS = 10
) (
  input  logic             tb_HCLK,
  input  logic             reset,
  input  aes_pkg::job_t    job,
  input  logic             start,
  input  logic             core_done,
  input  aes_pkg::block_t  core_result,
  input  logic             wr_done,
  input  logic             wr_error,
  output aes_pkg::status_t status,
  output logic             core_start,
  output aes_pkg::block_t  core_key,
  output aes_pkg::block_t  core_block,
  output logic             wr_valid,
  output aes_pkg::block_t  wr_data,
  output aes_pkg::word_t   wr_addr
);
  import aes_pkg::*;

  localparam int CW = $clog2(ROUNDS + 2);

  aes_state_e state_q;
  job_t       job_q;
  logic       err_q;
  logic [CW-1:0] cyc_cnt;

  assign core_key   = job_q.key;
  assign core_block = job_q.counter;
  assign wr_addr    = job_q.dest;

  assign status = '{busy:         state_q != ST_IDLE,
                    done_pulse:   state_q == ST_DONE,
                    bus_error:    err_q,
                    next_counter: job_q.counter[31:0] + 32'd1};

  always_ff @(posedge tb_HCLK)
  begin
    if (state_q == ST_IDLE && start)
      job_q <= job;
    // Keystream XOR plaintext
    if (state_q == ST_CIPHER && core_done)
      wr_data <= core_result ^ job_q.plaintext;
  end

  always_ff @(posedge tb_HCLK)
  begin
    if (reset)
    begin
      state_q    <= ST_IDLE;
      core_start <= 1'b0;
      wr_valid   <= 1'b0;
      err_q      <= 1'b0;
      cyc_cnt    <= '0;
    end
    else
    begin
      core_start <= 1'b0;
      case (state_q)
        ST_IDLE:
        begin
          if (start)
          begin
            core_start <= 1'b1;
            cyc_cnt    <= '0;
            state_q    <= ST_CIPHER;
          end
        end
        ST_CIPHER:
        begin
          cyc_cnt <= cyc_cnt + 1'b1;
          if (core_done)
          begin
            wr_valid <= 1'b1;
            state_q  <= ST_WRITE;
          end
        end
        ST_WRITE:
        begin
          if (wr_done)
          begin
            wr_valid <= 1'b0;
            err_q    <= wr_error;
            state_q  <= ST_DONE;
          end
        end
        default:
          state_q <= ST_IDLE;
      endcase
    end
  end

  a_start_in_idle: assert property (@(posedge tb_HCLK) disable iff (reset)
    start |-> state_q == ST_IDLE);

  // Core latency as seen from the controller
  a_core_latency: assert property (@(posedge tb_HCLK) disable iff (reset)
    core_done |-> state_q == ST_CIPHER && cyc_cnt == CW'(ROUNDS + 1));

endmodule

// File: verification/aes_ref_model.svh
// AES-128 encryption only, included inside the testbench module; call init_sbox before any encryption
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

logic [7:0] ref_sbox [256];

// Shift-and-add product in GF(2^8)
function automatic logic [7:0] ref_gmul(input logic [7:0] a, input logic [7:0] b);
  logic [7:0] p;
  logic [7:0] x;
  p = 8'h00;
  x = a;
  for (int i = 0; i < 8; i++)
  begin
    if (b[i])
      p = p ^ x;
    x = x[7] ? ({x[6:0], 1'b0} ^ 8'h1b) : {x[6:0], 1'b0};
  end
  return p;
endfunction

// Inverse found by search, zero maps to zero
function automatic void init_sbox();
  logic [7:0] inv;
  logic [7:0] s;
  for (int a = 0; a < 256; a++)
  begin
    inv = 8'h00;
    for (int b = 1; b < 256; b++)
    begin
      if (ref_gmul(8'(a), 8'(b)) == 8'h01)
        inv = 8'(b);
    end
    for (int i = 0; i < 8; i++)
      s[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^ inv[(i + 6) % 8]
             ^ inv[(i + 7) % 8] ^ 1'((8'h63 >> i) & 8'h01);
    ref_sbox[a] = s;
  end
endfunction

function automatic logic [127:0] aes128_encrypt(input logic [127:0] key, input logic [127:0] pt);
  logic [31:0]  w [44];
  logic [31:0]  t;
  logic [7:0]   s [4][4];
  logic [7:0]   m [4][4];
  logic [7:0]   rc;
  logic [127:0] out;
  for (int i = 0; i < 4; i++)
    w[i] = key[127 - 32 * i -: 32];
  rc = 8'h01;
  for (int i = 4; i < 44; i++)
  begin
    t = w[i - 1];
    if (i % 4 == 0)
    begin
      t = {ref_sbox[t[23:16]], ref_sbox[t[15:8]], ref_sbox[t[7:0]], ref_sbox[t[31:24]]}
          ^ {rc, 24'h000000};
      rc = ref_gmul(rc, 8'h02);
    end
    w[i] = w[i - 4] ^ t;
  end
  // State held as rows by columns
  for (int c = 0; c < 4; c++)
    for (int r = 0; r < 4; r++)
      s[r][c] = pt[127 - 8 * (4 * c + r) -: 8] ^ w[c][31 - 8 * r -: 8];
  for (int rnd = 1; rnd <= 10; rnd++)
  begin
    for (int r = 0; r < 4; r++)
      for (int c = 0; c < 4; c++)
        m[r][c] = ref_sbox[s[r][(c + r) % 4]];
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        if (rnd == 10)
          s[r][c] = m[r][c];
        else
          s[r][c] = ref_gmul(m[r][c], 8'h02) ^ ref_gmul(m[(r + 1) % 4][c], 8'h03)
                    ^ m[(r + 2) % 4][c] ^ m[(r + 3) % 4][c];
        s[r][c] = s[r][c] ^ w[4 * rnd + c][31 - 8 * r -: 8];
      end
    end
  end
  for (int c = 0; c < 4; c++)
    for (int r = 0; r < 4; r++)
      out[127 - 8 * (4 * c + r) -: 8] = s[r][c];
  return out;
endfunction

// Keystream from the counter block, XOR the plaintext
function automatic logic [127:0] ctr_expect(input logic [127:0] key, input logic [127:0] ctr,
                                            input logic [127:0] pt);
  return aes128_encrypt(key, ctr) ^ pt;
endfunction

`endif

// File: verification/tb_aes_block.sv
// Testbench for word-only AHB-Lite accesses; the memory model answers ERROR at one chosen address
`timescale 1ns/1ps

module tb_aes_block;
  import aes_pkg::*;

  localparam int CLK_PERIOD     = 4;
  localparam int MAX_JOBS       = 20;
  localparam int CYCLES_PER_JOB = 200;
  localparam int DONE_POLLS     = 100;
  localparam int RANDOM_JOBS    = 12;

  logic       tb_HCLK = 1'b0;
  logic       reset;
  logic       slave_hsel;
  word_t      slave_haddr;
  logic       slave_hwrite;
  logic [2:0] slave_hsize;
  logic [1:0] slave_htrans;
  logic       slave_hready;
  word_t      slave_hwdata;
  word_t      slave_hrdata;
  logic       slave_hreadyout;
  logic       slave_hresp;
  word_t      master_haddr;
  logic       master_hwrite;
  logic [2:0] master_hsize;
  logic [2:0] master_hburst;
  logic [1:0] master_htrans;
  word_t      master_hwdata;
  logic       master_hready = 1'b1;
  logic       master_hresp = 1'b0;

  // Memory model state
  word_t mem [word_t];
  logic  dp_valid = 1'b0;
  word_t dp_addr = '0;
  logic  err_cycle = 1'b0;
  logic  err_enable = 1'b0;
  word_t err_addr = '0;

  int errors = 0;
  int jobs = 0;

  `include "aes_ref_model.svh"

  aes_block #(.ROUNDS(10)) dut (.*);

  always #(CLK_PERIOD / 2) tb_HCLK = ~tb_HCLK;

  // Data phase completes on hready high without ERROR
  always @(posedge tb_HCLK)
  begin
    if (reset)
      dp_valid = 1'b0;
    else
    begin
      if (dp_valid && master_hready && !master_hresp)
        mem[dp_addr >> 2] = master_hwdata;
      if (master_hready)
      begin
        if (master_htrans[1])
          check_addr_phase();
        dp_valid = master_htrans[1];
        dp_addr  = master_haddr;
      end
    end
  end

  always @(negedge tb_HCLK)
  begin
    if (reset)
    begin
      master_hready = 1'b1;
      master_hresp  = 1'b0;
      err_cycle     = 1'b0;
    end
    else if (err_cycle)
    begin
      master_hready = 1'b1;
      master_hresp  = 1'b1;
      err_cycle     = 1'b0;
    end
    else if (!dp_valid)
    begin
      master_hready = 1'b1;
      master_hresp  = 1'b0;
    end
    else if (err_enable && dp_addr == err_addr)
    begin
      master_hready = 1'b0;
      master_hresp  = 1'b1;
      err_cycle     = 1'b1;
    end
    else
    begin
      master_hresp  = 1'b0;
      master_hready = ($urandom % 4) != 0;
    end
  end

  task automatic report_mismatch(input string name, input word_t got, input word_t exp);
    errors++;
    $display("[FAIL] %0t ns %s got %08h expected %08h", $time, name, got, exp);
  endtask

  task automatic note_problem(input string msg);
    errors++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  // Accepted address phase of the INCR4 write burst, compared with the previous one
  task automatic check_addr_phase();
    if (master_hwrite !== 1'b1)
      report_mismatch("master_hwrite", {31'd0, master_hwrite}, 32'h1);
    if (master_hsize !== HSIZE_WORD)
      report_mismatch("master_hsize", {29'd0, master_hsize}, {29'd0, HSIZE_WORD});
    if (master_hburst !== HBURST_INCR4)
      report_mismatch("master_hburst", {29'd0, master_hburst}, {29'd0, HBURST_INCR4});
    if (dp_valid)
    begin
      if (master_htrans !== HTRANS_SEQ)
        report_mismatch("master_htrans", {30'd0, master_htrans}, {30'd0, HTRANS_SEQ});
      if (master_haddr !== dp_addr + 32'd4)
        report_mismatch("master_haddr", master_haddr, dp_addr + 32'd4);
    end
    else if (master_htrans !== HTRANS_NONSEQ)
      report_mismatch("master_htrans", {30'd0, master_htrans}, {30'd0, HTRANS_NONSEQ});
  endtask

  // One single transfer, address phase then data phase
  task automatic bus_transfer(input logic write, input word_t addr, input word_t wdata,
                              output word_t rdata, output logic err);
    @(negedge tb_HCLK);
    slave_hsel   = 1'b1;
    slave_haddr  = addr;
    slave_hwrite = write;
    slave_hsize  = HSIZE_WORD;
    slave_htrans = HTRANS_NONSEQ;
    @(negedge tb_HCLK);
    slave_hsel   = 1'b0;
    slave_htrans = HTRANS_IDLE;
    if (write)
      slave_hwdata = wdata;
    #1;
    rdata = slave_hrdata;
    err   = 1'b0;
    if (!slave_hreadyout)
    begin
      err = 1'b1;
      if (!slave_hresp)
        note_problem("slave stalled without an ERROR response");
      @(negedge tb_HCLK);
      #1;
      if (!(slave_hresp && slave_hreadyout))
        note_problem("second ERROR cycle missing on the slave port");
    end
    else if (slave_hresp)
    begin
      err = 1'b1;
      note_problem("slave answered ERROR without a wait cycle");
    end
  endtask

  task automatic ahb_write(input word_t addr, input word_t data, output logic err);
    word_t unused;
    bus_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic ahb_read(input word_t addr, output word_t data, output logic err);
    bus_transfer(1'b0, addr, '0, data, err);
  endtask

  task automatic load_job(input block_t key, input block_t ctr, input block_t pt,
                          input word_t dest);
    logic err;
    for (int i = 0; i < 4; i++)
    begin
      ahb_write(REG_KEY0 + 4 * i, key[127 - 32 * i -: 32], err);
      if (err)
        note_problem("ERROR response while writing the key");
      ahb_write(REG_CTR0 + 4 * i, ctr[127 - 32 * i -: 32], err);
      if (err)
        note_problem("ERROR response while writing the counter");
      ahb_write(REG_PT0 + 4 * i, pt[127 - 32 * i -: 32], err);
      if (err)
        note_problem("ERROR response while writing the plaintext");
    end
    ahb_write(REG_DEST, dest, err);
    if (err)
      note_problem("ERROR response while writing the destination");
  endtask

  // Start and clear the sticky bits in one write
  task automatic start_job();
    logic err;
    mem.delete();
    jobs++;
    ahb_write(REG_CTRL, 32'h3, err);
    if (err)
      note_problem("ERROR response on the start write");
  endtask

  task automatic wait_done(output word_t st);
    logic err;
    for (int i = 0; i < DONE_POLLS; i++)
    begin
      ahb_read(REG_STATUS, st, err);
      if (st[1])
        return;
    end
    note_problem("status done did not rise");
  endtask

  task automatic check_burst(input word_t dest, input block_t exp);
    word_t a;
    if (mem.size() != 4)
      note_problem($sformatf("burst wrote %0d words instead of 4", mem.size()));
    for (int i = 0; i < 4; i++)
    begin
      a = (dest >> 2) + i;
      if (!mem.exists(a))
        note_problem($sformatf("no write reached address %08h", dest + 4 * i));
      else if (mem[a] !== exp[127 - 32 * i -: 32])
        report_mismatch($sformatf("mem[%08h]", dest + 4 * i), mem[a], exp[127 - 32 * i -: 32]);
    end
  endtask

  task automatic check_ctr3(input word_t exp);
    word_t rd;
    logic  err;
    ahb_read(REG_CTR3, rd, err);
    if (rd !== exp)
      report_mismatch("ctr3", rd, exp);
  endtask

  task automatic run_job(input block_t key, input block_t ctr, input block_t pt, input word_t dest);
    word_t st;
    load_job(key, ctr, pt, dest);
    start_job();
    wait_done(st);
    if (st[2:0] !== 3'b010)
      report_mismatch("status", st, 32'h2);
    check_burst(dest, ctr_expect(key, ctr, pt));
    check_ctr3(ctr[31:0] + 32'd1);
  endtask

  function automatic block_t random_block();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  initial
  begin
    #(MAX_JOBS * CYCLES_PER_JOB * CLK_PERIOD);
    $display("Watchdog expired before the tests finished, %0d jobs started", jobs);
    $display("Simulation FAILED");
    $finish;
  end

  initial
  begin
    block_t key;
    block_t ctr;
    block_t pt;
    word_t  dest;
    word_t  rd;
    word_t  st;
    logic   err;
    void'($urandom(32'hd40f));
    reset        = 1'b1;
    slave_hsel   = 1'b0;
    slave_haddr  = '0;
    slave_hwrite = 1'b0;
    slave_hsize  = HSIZE_WORD;
    slave_htrans = HTRANS_IDLE;
    slave_hready = 1'b1;
    slave_hwdata = '0;
    init_sbox();
    repeat (3) @(posedge tb_HCLK);
    @(negedge tb_HCLK);
    reset = 1'b0;
    if (master_htrans !== HTRANS_IDLE || slave_hreadyout !== 1'b1 || slave_hresp !== 1'b0)
      note_problem("bus outputs not idle after reset");

    // FIPS-197 vector, zero plaintext leaves the bare cipher output
    key = 128'h000102030405060708090a0b0c0d0e0f;
    ctr = 128'h00112233445566778899aabbccddeeff;
    if (aes128_encrypt(key, ctr) !== 128'h69c4e0d86a7b0430d8cdb78070b4c55a)
      note_problem("reference model does not reproduce the FIPS-197 vector");
    run_job(key, ctr, '0, 32'h0000_1000);
    check_burst(32'h0000_1000, 128'h69c4e0d86a7b0430d8cdb78070b4c55a);

    for (int j = 0; j < RANDOM_JOBS; j++)
    begin
      key  = random_block();
      ctr  = random_block();
      pt   = random_block();
      dest = $urandom & 32'hffff_fff0;
      run_job(key, ctr, pt, dest);
    end

    // Counter wraps, then a restart picks up the next value
    key       = random_block();
    ctr       = random_block();
    ctr[31:0] = 32'hffff_ffff;
    pt        = random_block();
    dest      = 32'h0000_2000;
    run_job(key, ctr, pt, dest);
    start_job();
    wait_done(st);
    check_burst(dest, ctr_expect(key, {ctr[127:32], 32'h0000_0000}, pt));
    check_ctr3(32'h0000_0001);

    // Readback, then busy protection
    key  = random_block();
    ctr  = random_block();
    pt   = random_block();
    dest = 32'h0000_3000;
    load_job(key, ctr, pt, dest);
    for (int i = 0; i < 4; i++)
    begin
      ahb_read(REG_KEY0 + 4 * i, rd, err);
      if (rd !== key[127 - 32 * i -: 32])
        report_mismatch($sformatf("key%0d", i), rd, key[127 - 32 * i -: 32]);
      ahb_read(REG_PT0 + 4 * i, rd, err);
      if (rd !== pt[127 - 32 * i -: 32])
        report_mismatch($sformatf("pt%0d", i), rd, pt[127 - 32 * i -: 32]);
    end
    ahb_read(REG_DEST, rd, err);
    if (rd !== dest)
      report_mismatch("dest", rd, dest);
    start_job();
    ahb_read(REG_STATUS, rd, err);
    if (rd[0] !== 1'b1)
      report_mismatch("status busy", {31'd0, rd[0]}, 32'h1);
    ahb_write(REG_KEY0, ~key[127:96], err);
    if (!err)
      note_problem("write to key0 while busy was accepted");
    ahb_read(REG_KEY0, rd, err);
    if (rd !== key[127:96])
      report_mismatch("key0", rd, key[127:96]);
    ahb_read(32'h0000_003C, rd, err);
    if (!err)
      note_problem("unmapped address got no ERROR response");
    wait_done(st);
    check_burst(dest, ctr_expect(key, ctr, pt));

    // Master ERROR on the third beat
    dest       = 32'h0000_4000;
    err_addr   = dest + 32'd8;
    err_enable = 1'b1;
    load_job(random_block(), random_block(), random_block(), dest);
    start_job();
    wait_done(st);
    err_enable = 1'b0;
    if (st[2:0] !== 3'b110)
      report_mismatch("status", st, 32'h6);
    ahb_write(REG_CTRL, 32'h2, err);
    ahb_read(REG_STATUS, rd, err);
    if (rd !== 32'h0)
      report_mismatch("status", rd, 32'h0);

    $display("Finished %0d jobs with %0d errors", jobs, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule
